// File: common/rv_consts.svh
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

`default_nettype none

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Widths and sizes.
`define RV_XLEN         32
`define RV_ILEN         32
`define RV_REG_IDX_W    5
`define RV_REG_COUNT    32

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Major opcodes kept by this core.
`define RV_OPC_OP       7'b0110011
`define RV_OPC_OP_IMM   7'b0010011
`define RV_OPC_LUI      7'b0110111

// funct7 values, ALT selects SUB and SRA.
`define RV_F7_BASE      7'b0000000
`define RV_F7_ALT       7'b0100000

// funct3 values shared by OP and OP-IMM.
`define RV_F3_ADD_SUB   3'b000
`define RV_F3_SLL       3'b001
`define RV_F3_SLT       3'b010
`define RV_F3_SLTU      3'b011
`define RV_F3_XOR       3'b100
`define RV_F3_SRL_SRA   3'b101
`define RV_F3_OR        3'b110
`define RV_F3_AND       3'b111

`default_nettype wire

`endif

// File: common/rv_pkg.sv
`include "rv_consts.svh"

`default_nettype none

package rv_pkg;

    typedef logic [`RV_XLEN-1:0]        word_t;
    typedef logic [`RV_REG_IDX_W-1:0]   reg_idx_t;
    typedef logic [`RV_ILEN-1:0]        instr_t;

    // Operations the ALU knows.
    typedef enum logic [3:0]
    {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B      // LUI
    } alu_op_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Decode stage register.
    typedef struct packed
    {
        alu_op_t    alu_op;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        reg_idx_t   rd;
        word_t      op1;
        word_t      op2;
        word_t      imm;
        logic       use_imm;
        logic       zero_op1;
        logic       reg_write;
        logic       illegal;
    } dec_bundle_t;

    // Writeback stage register, also the output stream payload.
    typedef struct packed
    {
        reg_idx_t   rd;
        word_t      data;
        logic       reg_write;
        logic       illegal;
    } wb_bundle_t;

endpackage

`default_nettype wire

// File: rtl/rv_regs.sv
`include "rv_consts.svh"

`default_nettype none

module rv_regs
(
    input  wire                     i_clk,
    input  wire                     i_reset,
    input  wire rv_pkg::reg_idx_t   i_rs1_idx,
    input  wire rv_pkg::reg_idx_t   i_rs2_idx,
    output rv_pkg::word_t           o_rs1_data,
    output rv_pkg::word_t           o_rs2_data,
    input  wire                     i_wr_en,
    input  wire rv_pkg::reg_idx_t   i_wr_idx,
    input  wire rv_pkg::word_t      i_wr_data
);
    import rv_pkg::*;

    word_t  regs [`RV_REG_COUNT];
    logic   wr_live;

    // x0 is never written.
    assign wr_live = i_wr_en && (i_wr_idx != '0);

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            for (int i = 0; i < `RV_REG_COUNT; i++)
                regs[i] <= '0;
        end
        else if (wr_live)
            regs[i_wr_idx] <= i_wr_data;
    end

    // Write-through so a reader in the retire cycle sees the new value.
    assign o_rs1_data = (i_rs1_idx == '0) ? '0 :
                        (wr_live && i_rs1_idx == i_wr_idx) ? i_wr_data : regs[i_rs1_idx];
    assign o_rs2_data = (i_rs2_idx == '0) ? '0 :
                        (wr_live && i_rs2_idx == i_wr_idx) ? i_wr_data : regs[i_rs2_idx];

endmodule

`default_nettype wire

// File: rtl/rv_decode.sv
`include "rv_consts.svh"

`default_nettype none

module rv_decode
(
    input  wire                     i_clk,
    input  wire                     i_reset,
    input  wire                     i_advance,
    input  wire                     i_instr_valid,
    input  wire rv_pkg::instr_t     i_instr,
    output rv_pkg::reg_idx_t        o_rs1_idx,
    output rv_pkg::reg_idx_t        o_rs2_idx,
    input  wire rv_pkg::word_t      i_rs1_data,
    input  wire rv_pkg::word_t      i_rs2_data,
    output logic                    o_dec_valid,
    output rv_pkg::dec_bundle_t     o_dec
);
    import rv_pkg::*;

    logic [6:0]     opcode;
    logic [2:0]     funct3;
    logic [6:0]     funct7;
    reg_idx_t       rd;
    word_t          imm_i;
    word_t          imm_u;
    logic           is_op;
    logic           is_op_imm;
    logic           is_lui;
    alu_op_t        alu_op;
    logic           f7_ok;
    logic           legal;
    dec_bundle_t    dec_next;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Fields and immediates.
    assign opcode    = i_instr[6:0];
    assign rd        = i_instr[11:7];
    assign funct3    = i_instr[14:12];
    assign o_rs1_idx = i_instr[19:15];
    assign o_rs2_idx = i_instr[24:20];
    assign funct7    = i_instr[31:25];

    assign imm_i = {{20{i_instr[31]}}, i_instr[31:20]};
    assign imm_u = {i_instr[31:12], 12'b0};

    assign is_op     = (opcode == `RV_OPC_OP);
    assign is_op_imm = (opcode == `RV_OPC_OP_IMM);
    assign is_lui    = (opcode == `RV_OPC_LUI);

    always_comb
    begin
        case (funct3)
            `RV_F3_ADD_SUB: alu_op = (is_op && funct7 == `RV_F7_ALT) ? ALU_SUB : ALU_ADD;
            `RV_F3_SLL:     alu_op = ALU_SLL;
            `RV_F3_SLT:     alu_op = ALU_SLT;
            `RV_F3_SLTU:    alu_op = ALU_SLTU;
            `RV_F3_XOR:     alu_op = ALU_XOR;
            `RV_F3_SRL_SRA: alu_op = (funct7 == `RV_F7_ALT) ? ALU_SRA : ALU_SRL;
            `RV_F3_OR:      alu_op = ALU_OR;
            `RV_F3_AND:     alu_op = ALU_AND;
            default:        alu_op = ALU_ADD;
        endcase
    end

    // ALT is only valid for SUB and the right shifts.
    always_comb
    begin
        if (funct7 == `RV_F7_BASE)
            f7_ok = 1'b1;
        else if (funct7 == `RV_F7_ALT)
            f7_ok = (is_op && funct3 == `RV_F3_ADD_SUB) || (funct3 == `RV_F3_SRL_SRA);
        else
            f7_ok = 1'b0;
    end

    // For OP-IMM funct7 is immediate bits unless it is a shift.
    assign legal = is_lui || (is_op && f7_ok) ||
                   (is_op_imm && (f7_ok || (funct3 != `RV_F3_SLL && funct3 != `RV_F3_SRL_SRA)));

    always_comb
    begin
        dec_next.alu_op    = is_lui ? ALU_PASS_B : alu_op;
        dec_next.rs1       = o_rs1_idx;
        dec_next.rs2       = o_rs2_idx;
        dec_next.rd        = rd;
        dec_next.op1       = i_rs1_data;
        dec_next.op2       = i_rs2_data;
        dec_next.imm       = is_lui ? imm_u : imm_i;
        dec_next.use_imm   = is_op_imm || is_lui;
        dec_next.zero_op1  = is_lui;
        dec_next.reg_write = legal;
        dec_next.illegal   = !legal;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stage register.
    always_ff @(posedge i_clk)
    begin
        if (i_reset)
            o_dec_valid <= 1'b0;
        else if (i_advance)
            o_dec_valid <= i_instr_valid;
    end

    always_ff @(posedge i_clk)
    begin
        if (i_advance)
            o_dec <= dec_next;
    end

endmodule

`default_nettype wire

// File: rtl/rv_execute.sv
`include "rv_consts.svh"

`default_nettype none

module rv_execute
(
    input  wire                         i_clk,
    input  wire                         i_reset,
    input  wire                         i_advance,
    input  wire                         i_dec_valid,
    input  wire rv_pkg::dec_bundle_t    i_dec,
    output logic                        o_wb_valid,
    output rv_pkg::wb_bundle_t          o_wb
);
    import rv_pkg::*;

    logic           fwd_ok;
    word_t          op1_fwd;
    word_t          op2_fwd;
    word_t          alu_a;
    word_t          alu_b;
    logic [4:0]     shamt;
    word_t          result;
    wb_bundle_t     wb_next;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Forwarding from the output register.
    assign fwd_ok  = o_wb_valid && o_wb.reg_write && (o_wb.rd != '0);
    assign op1_fwd = (fwd_ok && o_wb.rd == i_dec.rs1) ? o_wb.data : i_dec.op1;
    assign op2_fwd = (fwd_ok && o_wb.rd == i_dec.rs2) ? o_wb.data : i_dec.op2;

    // Operand select, LUI adds onto zero.
    assign alu_a = i_dec.zero_op1 ? '0 : op1_fwd;
    assign alu_b = i_dec.use_imm ? i_dec.imm : op2_fwd;
    assign shamt = alu_b[4:0];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // ALU.
    always_comb
    begin
        case (i_dec.alu_op)
            ALU_ADD:    result = alu_a + alu_b;
            ALU_SUB:    result = alu_a - alu_b;
            ALU_SLL:    result = alu_a << shamt;
            ALU_SLT:    result = {{(`RV_XLEN-1){1'b0}}, $signed(alu_a) < $signed(alu_b)};
            ALU_SLTU:   result = {{(`RV_XLEN-1){1'b0}}, alu_a < alu_b};
            ALU_XOR:    result = alu_a ^ alu_b;
            ALU_SRL:    result = alu_a >> shamt;
            ALU_SRA:    result = word_t'($signed(alu_a) >>> shamt);
            ALU_OR:     result = alu_a | alu_b;
            ALU_AND:    result = alu_a & alu_b;
            ALU_PASS_B: result = alu_b;
            default:    result = '0;
        endcase
    end

    always_comb
    begin
        wb_next.rd        = i_dec.rd;
        // Illegal instructions retire a clean zero.
        wb_next.data      = i_dec.illegal ? '0 : result;
        wb_next.reg_write = i_dec.reg_write;
        wb_next.illegal   = i_dec.illegal;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Output register, held while the consumer stalls.
    always_ff @(posedge i_clk)
    begin
        if (i_reset)
            o_wb_valid <= 1'b0;
        else if (i_advance)
            o_wb_valid <= i_dec_valid;
    end

    always_ff @(posedge i_clk)
    begin
        if (i_advance)
            o_wb <= wb_next;
    end

endmodule

`default_nettype wire

// File: rtl/rv_core.sv
`default_nettype none

module rv_core
(
    input  wire                     i_clk,
    input  wire                     i_reset,
    input  wire                     i_instr_valid,
    input  wire rv_pkg::instr_t     i_instr,
    output logic                    o_instr_ready,
    output logic                    o_wb_valid,
    output rv_pkg::wb_bundle_t      o_wb,
    input  wire                     i_wb_ready
);
    import rv_pkg::*;

    logic           advance;
    reg_idx_t       rs1_idx;
    reg_idx_t       rs2_idx;
    word_t          rs1_data;
    word_t          rs2_data;
    logic           dec_valid;
    dec_bundle_t    dec;
    logic           wr_en;

    // Whole pipeline moves as one, any stall freezes every stage.
    assign advance       = !o_wb_valid || i_wb_ready;
    assign o_instr_ready = advance;

    // Registers are written as the result retires.
    assign wr_en = o_wb_valid && i_wb_ready && o_wb.reg_write;

    rv_decode
    u_decode
    (
        .i_clk              (i_clk),
        .i_reset            (i_reset),
        .i_advance          (advance),
        .i_instr_valid      (i_instr_valid),
        .i_instr            (i_instr),
        .o_rs1_idx          (rs1_idx),
        .o_rs2_idx          (rs2_idx),
        .i_rs1_data         (rs1_data),
        .i_rs2_data         (rs2_data),
        .o_dec_valid        (dec_valid),
        .o_dec              (dec)
    );

    rv_execute
    u_execute
    (
        .i_clk              (i_clk),
        .i_reset            (i_reset),
        .i_advance          (advance),
        .i_dec_valid        (dec_valid),
        .i_dec              (dec),
        .o_wb_valid         (o_wb_valid),
        .o_wb               (o_wb)
    );

    rv_regs
    u_regs
    (
        .i_clk              (i_clk),
        .i_reset            (i_reset),
        .i_rs1_idx          (rs1_idx),
        .i_rs2_idx          (rs2_idx),
        .o_rs1_data         (rs1_data),
        .o_rs2_data         (rs2_data),
        .i_wr_en            (wr_en),
        .i_wr_idx           (o_wb.rd),
        .i_wr_data          (o_wb.data)
    );

endmodule

`default_nettype wire

// File: tb/rv_core_assert.sv
`default_nettype none

module rv_core_assert
(
    input  wire                     i_clk,
    input  wire                     i_reset,
    input  wire                     i_instr_valid,
    input  wire                     o_instr_ready,
    input  wire                     o_wb_valid,
    input  wire rv_pkg::wb_bundle_t o_wb,
    input  wire                     i_wb_ready
);
    timeunit 1ns;
    timeprecision 1ps;

    int failures = 0;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Output stream rules.
    property wb_hold_p;
        @(posedge i_clk) disable iff (i_reset)
        (o_wb_valid && !i_wb_ready) |=> (o_wb_valid && $stable(o_wb));
    endproperty

    property wb_reset_p;
        @(posedge i_clk) i_reset |=> !o_wb_valid;
    endproperty

    // An accepted instruction reaches the output two edges later when nothing stalls.
    property wb_latency_p;
        @(posedge i_clk) disable iff (i_reset)
        (o_instr_ready && $past(i_instr_valid && o_instr_ready)) |=> o_wb_valid;
    endproperty

    assert property (wb_hold_p)
    else
    begin
        failures++;
        $error("o_wb changed or dropped while the consumer stalled");
    end

    assert property (wb_reset_p)
    else
    begin
        failures++;
        $error("o_wb_valid high in the cycle after reset");
    end

    assert property (wb_latency_p)
    else
    begin
        failures++;
        $error("accepted instruction did not reach the output two cycles later");
    end

endmodule

bind rv_core rv_core_assert u_assert
(
    .i_clk          (i_clk),
    .i_reset        (i_reset),
    .i_instr_valid  (i_instr_valid),
    .o_instr_ready  (o_instr_ready),
    .o_wb_valid     (o_wb_valid),
    .o_wb           (o_wb),
    .i_wb_ready     (i_wb_ready)
);

`default_nettype wire

// File: tb/rv_core_tb.sv
`default_nettype none

module rv_core_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import rv_pkg::*;

    localparam int MAX_TESTS  = 64;
    localparam int FIELDS     = 5;
    localparam int CLK_PERIOD = 20;

    logic           i_clk;
    logic           i_reset;
    logic           i_instr_valid;
    instr_t         i_instr;
    logic           o_instr_ready;
    logic           o_wb_valid;
    wb_bundle_t     o_wb;
    logic           i_wb_ready;

    logic [31:0]    test_mem [MAX_TESTS * FIELDS];
    int             gap_len [MAX_TESTS];
    int             num_tests;
    int             num_retired;
    int             error_count;
    int             assert_count;
    integer         seed;

    rv_core UUT
    (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_instr_valid  (i_instr_valid),
        .i_instr        (i_instr),
        .o_instr_ready  (o_instr_ready),
        .o_wb_valid     (o_wb_valid),
        .o_wb           (o_wb),
        .i_wb_ready     (i_wb_ready)
    );

    initial
    begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Helpers.
    task automatic compare_values(input string what, input logic [31:0] got,
                                  input logic [31:0] expected);
        if (got !== expected)
        begin
            $display("Mismatch at time %0t: %s, got %h, expected %h", $time, what, got,
                     expected);
            error_count++;
        end
    endtask

    // Unused slots keep an rd above 31, which marks the end of the list.
    task automatic load_tests();
        for (int i = 0; i < MAX_TESTS * FIELDS; i++)
            test_mem[i] = 32'hfff0_0000 | i;
        $readmemh("tb/rv_core_tests.txt", test_mem);
        num_tests = 0;
        while (num_tests < MAX_TESTS && test_mem[num_tests * FIELDS + 1] < 32)
            num_tests++;
    endtask

    task automatic drive_instructions();
        for (int t = 0; t < num_tests; t++)
        begin
            if (gap_len[t] > 0)
            begin
                i_instr_valid <= 1'b0;
                repeat (gap_len[t]) @(posedge i_clk);
            end
            i_instr_valid <= 1'b1;
            i_instr       <= test_mem[t * FIELDS];
            @(posedge i_clk);
            while (!o_instr_ready)
                @(posedge i_clk);
        end
        i_instr_valid <= 1'b0;
    endtask

    task automatic monitor_results();
        int idx;
        while (num_retired < num_tests)
        begin
            @(posedge i_clk);
            if (o_wb_valid && i_wb_ready)
            begin
                idx = num_retired * FIELDS;
                compare_values($sformatf("test %0d rd", num_retired), 32'(o_wb.rd),
                               test_mem[idx + 1]);
                compare_values($sformatf("test %0d data", num_retired), o_wb.data,
                               test_mem[idx + 2]);
                compare_values($sformatf("test %0d reg_write", num_retired),
                               32'(o_wb.reg_write), test_mem[idx + 3]);
                compare_values($sformatf("test %0d illegal", num_retired),
                               32'(o_wb.illegal), test_mem[idx + 4]);
                num_retired++;
            end
            i_wb_ready <= ($random(seed) & 3) != 0;
        end
        // Pipeline should be empty now.
        i_wb_ready <= 1'b1;
        repeat (10)
        begin
            @(posedge i_clk);
            if (o_wb_valid && i_wb_ready)
            begin
                $display("An extra result retired after the last test at time %0t", $time);
                error_count++;
            end
        end
    endtask

    task automatic watch_for_stall();
        repeat (num_tests * 8 + 100) @(posedge i_clk);
        $display("Timeout: results stopped arriving, %0d of %0d retired", num_retired,
                 num_tests);
        $display("TB FAILED");
        $finish;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Main sequence.
    initial
    begin
        i_reset       = 1'b1;
        i_instr_valid = 1'b0;
        i_instr       = '0;
        i_wb_ready    = 1'b0;
        seed          = 32'h76e2435b;
        error_count   = 0;
        num_retired   = 0;
        load_tests();
        if (num_tests == 0)
        begin
            $display("No tests were read from the data file");
            error_count++;
        end
        // Mostly back to back, sometimes a short gap.
        for (int t = 0; t < MAX_TESTS; t++)
            gap_len[t] = (($random(seed) & 7) < 5) ? 0 : 1 + ($random(seed) & 1);
        fork
            watch_for_stall();
        join_none
        repeat (5) @(posedge i_clk);
        i_reset <= 1'b0;
        fork
            drive_instructions();
            monitor_results();
        join
        assert_count = UUT.u_assert.failures;
        $display("Errors: %0d, assertion failures: %0d, retired %0d of %0d", error_count,
                 assert_count, num_retired, num_tests);
        if (error_count == 0 && assert_count == 0 && num_retired == num_tests)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/rv_core_tests.txt
// Columns: instruction, expected rd, expected data, reg_write, illegal (all hex).
// Registers start at zero; one retired instruction per line, in order.
00500093 01 00000005 1 0
ffd00113 02 fffffffd 1 0
002081b3 03 00000002 1 0
40208233 04 00000008 1 0
001122b3 05 00000001 1 0
00113333 06 00000000 1 0
40115393 07 fffffffe 1 0
01c15413 08 0000000f 1 0
00409493 09 00000050 1 0
12345537 0a 12345000 1 0
67850513 0a 12345678 1 0
fff54593 0b edcba987 1 0
00708013 00 0000000c 1 0
00100633 0c 00000005 1 0
000001ff 03 00000000 0 1
00018693 0d 00000002 1 0
4020c733 0e 00000000 0 1
00b567b3 0f ffffffff 1 0
0027f833 10 fffffffd 1 0
409158b3 11 ffffffff 1 0
ffe12913 12 00000001 1 0
fff0b993 13 00000001 1 0
0f05fa13 14 00000080 1 0
00809ab3 15 00028000 1 0

// File: all.f
+incdir+common
common/rv_pkg.sv
rtl/rv_regs.sv
rtl/rv_decode.sv
rtl/rv_execute.sv
rtl/rv_core.sv
tb/rv_core_assert.sv
tb/rv_core_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module rv_core_tb -f all.f -o rv_core_sim

./obj_dir/rv_core_sim +verilator+error+limit+100 > sim.log 2>&1
cat sim.log

if grep -q "TB FAILED" sim.log; then
    exit 1
fi
exit 0
